//--- src/cadr_mem_pkg.sv
// Memory geometry for the A and M memories, host load record
// and the credit depths of both streams
`default_nettype none

package cadr_mem_pkg;

   localparam int AMEM_WORDS = 1024;
   localparam int AMEM_AW = 10;
   localparam int MMEM_WORDS = 32;
   localparam int MMEM_AW = 5;
   localparam int WORD_W = 32;

   // Input queue depth equals the producer's starting credits
   localparam int UINST_CREDITS = 2;
   localparam int RESULT_CREDITS = 4;

   // Pointer, occupancy and credit counter widths
   localparam int UQ_PW = $clog2(UINST_CREDITS);
   localparam int UQ_CW = $clog2(UINST_CREDITS + 1);
   localparam int RC_W = $clog2(RESULT_CREDITS + 1);

   // Host load, to_m selects M-memory, otherwise A-memory
   typedef struct packed {
      logic                valid;
      logic                to_m;
      logic [AMEM_AW-1:0]  addr;
      logic [WORD_W-1:0]   data;
   } mem_load_t;

endpackage

`default_nettype wire

//--- src/cadr_uinst_pkg.sv
// Microinstruction formats, opcodes, the ALU/byte union
// and the result record
`default_nettype none

package cadr_uinst_pkg;

   localparam int BYTE_FW = 5;

   typedef enum logic [0:0] {
      KIND_ALU  = 1'b0,
      KIND_BYTE = 1'b1
   } uinst_kind_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_A,
      ALU_PASS_M,
      ALU_SETZ
   } alu_op_e;

   typedef enum logic [0:0] {
      BYTE_LDB,
      BYTE_DPB
   } byte_op_e;

   // Leading 27 bits are common to both formats
   typedef struct packed {
      uinst_kind_e                        kind;
      logic                               dest_to_m;
      logic [cadr_mem_pkg::AMEM_AW-1:0]   dest_addr;
      logic [cadr_mem_pkg::AMEM_AW-1:0]   a_addr;
      logic [cadr_mem_pkg::MMEM_AW-1:0]   m_addr;
      alu_op_e                            alu_op;
      logic [17:0]                        pad;
   } alu_fmt_t;

   typedef struct packed {
      uinst_kind_e                        kind;
      logic                               dest_to_m;
      logic [cadr_mem_pkg::AMEM_AW-1:0]   dest_addr;
      logic [cadr_mem_pkg::AMEM_AW-1:0]   a_addr;
      logic [cadr_mem_pkg::MMEM_AW-1:0]   m_addr;
      byte_op_e                           byte_op;
      logic [BYTE_FW-1:0]                 pos;
      logic [BYTE_FW-1:0]                 len;
      logic [9:0]                         pad;
   } byte_fmt_t;

   typedef union packed {
      alu_fmt_t   alu;
      byte_fmt_t  bfld;
   } uinst_u;

   typedef struct packed {
      logic    valid;
      uinst_u  uinst;
   } uinst_in_t;

   typedef struct packed {
      logic                               valid;
      logic                               dest_to_m;
      logic [cadr_mem_pkg::AMEM_AW-1:0]   dest_addr;
      logic [cadr_mem_pkg::WORD_W-1:0]    data;
   } result_t;

endpackage

`default_nettype wire

//--- src/amem_dpram.sv
// A-memory, 1k x 32 dual-port synchronous RAM
// Port a reads and takes host writes, port b takes write-back
`timescale 1ns/1ps
`default_nettype none

module amem_dpram (
   input  wire logic                               clk_a,
   input  wire logic                               reset,
   input  wire logic [cadr_mem_pkg::AMEM_AW-1:0]   address_a,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0]    data_a,
   input  wire logic                               wren_a,
   input  wire logic                               rden_a,
   output logic [cadr_mem_pkg::WORD_W-1:0]         q_a,
   input  wire logic [cadr_mem_pkg::AMEM_AW-1:0]   address_b,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0]    data_b,
   input  wire logic                               wren_b
);
   import cadr_mem_pkg::*;

   logic [WORD_W-1:0] ram [AMEM_WORDS];

   // Port a wins when both ports write
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         ram[address_a] <= data_a;
      else if (wren_b)
         ram[address_b] <= data_b;
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= ram[address_a];
   end

   // Host loads and pipeline write-back never overlap
   a_single_writer: assert property (@(posedge clk_a) disable iff (reset)
      !(wren_a && wren_b));

endmodule

`default_nettype wire

//--- src/mmem_regfile.sv
// M-memory, 32 x 32 register file with registered read
`timescale 1ns/1ps
`default_nettype none

module mmem_regfile (
   input  wire logic                               clk_a,
   input  wire logic                               reset,
   input  wire logic [cadr_mem_pkg::MMEM_AW-1:0]   raddr,
   input  wire logic                               rden,
   output logic [cadr_mem_pkg::WORD_W-1:0]         rdata,
   input  wire logic [cadr_mem_pkg::MMEM_AW-1:0]   waddr,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0]    wdata,
   input  wire logic                               wren
);
   import cadr_mem_pkg::*;

   logic [WORD_W-1:0] regs [MMEM_WORDS];

   always_ff @(posedge clk_a)
   begin
      if (wren)
         regs[waddr] <= wdata;
   end

   // Read returns the old word when raddr equals waddr
   always_ff @(posedge clk_a)
   begin
      if (reset)
         rdata <= '0;
      else if (rden)
         rdata <= regs[raddr];
   end

endmodule

`default_nettype wire

//--- src/alu_unit.sv
// Combinational ALU over the A and M operands
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
   input  wire cadr_uinst_pkg::alu_op_e         op,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0] a,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0] m,
   output logic [cadr_mem_pkg::WORD_W-1:0]      y
);
   import cadr_uinst_pkg::*;

   // Sums wrap at 32 bits
   always_comb
   begin
      case (op)
         ALU_ADD:
            y = a + m;
         ALU_SUB:
            y = a - m;
         ALU_AND:
            y = a & m;
         ALU_OR:
            y = a | m;
         ALU_XOR:
            y = a ^ m;
         ALU_PASS_A:
            y = a;
         ALU_PASS_M:
            y = m;
         ALU_SETZ:
            y = '0;
         default:
            y = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/byte_unit.sv
// Rotate-and-mask unit for load-byte and deposit-byte
`timescale 1ns/1ps
`default_nettype none

module byte_unit (
   input  wire cadr_uinst_pkg::byte_op_e                 op,
   input  wire logic [cadr_uinst_pkg::BYTE_FW-1:0]       pos,
   input  wire logic [cadr_uinst_pkg::BYTE_FW-1:0]       len,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0]          a,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0]          m,
   output logic [cadr_mem_pkg::WORD_W-1:0]               y
);
   import cadr_mem_pkg::*;
   import cadr_uinst_pkg::*;

   logic [WORD_W-1:0] mask;
   logic [WORD_W-1:0] dep_mask;

   function automatic logic [WORD_W-1:0] rotl(
      input logic [WORD_W-1:0]   x,
      input logic [BYTE_FW-1:0]  sh
   );
      logic [2*WORD_W-1:0] w;
      w = {x, x} << sh;
      return w[2*WORD_W-1:WORD_W];
   endfunction

   function automatic logic [WORD_W-1:0] rotr(
      input logic [WORD_W-1:0]   x,
      input logic [BYTE_FW-1:0]  sh
   );
      logic [2*WORD_W-1:0] w;
      w = {x, x} >> sh;
      return w[WORD_W-1:0];
   endfunction

   // len+1 ones from bit 0, len 31 gives a full word
   assign mask = {WORD_W{1'b1}} >> (BYTE_FW'(WORD_W - 1) - len);
   assign dep_mask = rotl(mask, pos);

   always_comb
   begin
      if (op == BYTE_LDB)
         y = rotr(m, pos) & mask;
      else
         y = (a & ~dep_mask) | (rotl(m, pos) & dep_mask);
   end

endmodule

`default_nettype wire

//--- src/uinst_ctrl.sv
// Microinstruction controller: input queue, credits, issue,
// operand bypass, write-back and result register
`timescale 1ns/1ps
`default_nettype none

module uinst_ctrl (
   input  wire logic                                  clk_a,
   input  wire logic                                  reset,
   input  wire cadr_uinst_pkg::uinst_in_t             uinst_in,
   output logic                                       uinst_credit,
   input  wire logic                                  result_credit,
   output cadr_uinst_pkg::result_t                    result_out,
   output logic [cadr_mem_pkg::AMEM_AW-1:0]           amem_raddr,
   output logic                                       amem_rden,
   output logic [cadr_mem_pkg::MMEM_AW-1:0]           mmem_raddr,
   output logic                                       mmem_rden,
   output logic [cadr_mem_pkg::AMEM_AW-1:0]           wb_a_addr,
   output logic [cadr_mem_pkg::WORD_W-1:0]            wb_a_data,
   output logic                                       wb_a_wren,
   output logic [cadr_mem_pkg::MMEM_AW-1:0]           mmem_waddr,
   output logic [cadr_mem_pkg::WORD_W-1:0]            mmem_wdata,
   output logic                                       mmem_wren,
   input  wire cadr_mem_pkg::mem_load_t               host_load,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0]       amem_q,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0]       mmem_q,
   output cadr_uinst_pkg::alu_op_e                    alu_op,
   output cadr_uinst_pkg::byte_op_e                   byte_op,
   output logic [cadr_uinst_pkg::BYTE_FW-1:0]         byte_pos,
   output logic [cadr_uinst_pkg::BYTE_FW-1:0]         byte_len,
   output logic [cadr_mem_pkg::WORD_W-1:0]            opnd_a,
   output logic [cadr_mem_pkg::WORD_W-1:0]            opnd_m,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0]       alu_y,
   input  wire logic [cadr_mem_pkg::WORD_W-1:0]       byte_y
);
   import cadr_mem_pkg::*;
   import cadr_uinst_pkg::*;

   typedef struct packed {
      uinst_kind_e         kind;
      logic                dest_to_m;
      logic [AMEM_AW-1:0]  dest_addr;
      logic [AMEM_AW-1:0]  a_addr;
      logic [MMEM_AW-1:0]  m_addr;
      alu_op_e             alu_op;
      byte_op_e            byte_op;
      logic [BYTE_FW-1:0]  pos;
      logic [BYTE_FW-1:0]  len;
   } stage_t;

   uinst_u              queue [UINST_CREDITS];
   logic [UQ_PW-1:0]    rd_ptr;
   logic [UQ_PW-1:0]    wr_ptr;
   logic [UQ_CW-1:0]    q_count;
   logic [RC_W-1:0]     rcred;
   uinst_u              head;
   logic                issue;
   stage_t              dec;
   stage_t              s1;
   stage_t              s2;
   logic                s1_valid;
   logic                s2_valid;
   logic [WORD_W-1:0]   wb_y;
   logic                host_m;
   logic                a_hit_wb;
   logic                a_hit_res;
   logic                m_hit_wb;
   logic                m_hit_res;

   assign head = queue[rd_ptr];
   assign issue = (q_count != '0) && (rcred != '0);

   always_ff @(posedge clk_a)
   begin
      if (uinst_in.valid)
         queue[wr_ptr] <= uinst_in.uinst;
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         q_count <= '0;
         rcred <= RC_W'(RESULT_CREDITS);
         uinst_credit <= 1'b0;
      end
      else
      begin
         if (uinst_in.valid)
            wr_ptr <= (wr_ptr == UQ_PW'(UINST_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
         if (issue)
            rd_ptr <= (rd_ptr == UQ_PW'(UINST_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
         q_count <= q_count + UQ_CW'(uinst_in.valid) - UQ_CW'(issue);
         rcred <= rcred + RC_W'(result_credit) - RC_W'(issue);
         // Queue slot freed, hand the credit back
         uinst_credit <= issue;
      end
   end

   // Common fields read through the ALU view
   always_comb
   begin
      dec.kind = head.alu.kind;
      dec.dest_to_m = head.alu.dest_to_m;
      dec.dest_addr = head.alu.dest_addr;
      dec.a_addr = head.alu.a_addr;
      dec.m_addr = head.alu.m_addr;
      dec.alu_op = head.alu.alu_op;
      dec.byte_op = head.bfld.byte_op;
      dec.pos = head.bfld.pos;
      dec.len = head.bfld.len;
   end

   assign amem_raddr = host_load.valid ? host_load.addr : head.alu.a_addr;
   assign amem_rden = issue;
   assign mmem_raddr = head.alu.m_addr;
   assign mmem_rden = issue;

   // Newest write first: this edge's write-back, then last edge's
   assign wb_y = (s2.kind == KIND_BYTE) ? byte_y : alu_y;
   assign a_hit_wb = s2_valid && !s2.dest_to_m && (s2.dest_addr == s1.a_addr);
   assign a_hit_res = result_out.valid && !result_out.dest_to_m
                      && (result_out.dest_addr == s1.a_addr);
   assign m_hit_wb = s2_valid && s2.dest_to_m
                     && (s2.dest_addr[MMEM_AW-1:0] == s1.m_addr);
   assign m_hit_res = result_out.valid && result_out.dest_to_m
                      && (result_out.dest_addr[MMEM_AW-1:0] == s1.m_addr);

   always_ff @(posedge clk_a)
   begin
      s1 <= dec;
      s2 <= s1;
      if (a_hit_wb)
         opnd_a <= wb_y;
      else if (a_hit_res)
         opnd_a <= result_out.data;
      else
         opnd_a <= amem_q;
      if (m_hit_wb)
         opnd_m <= wb_y;
      else if (m_hit_res)
         opnd_m <= result_out.data;
      else
         opnd_m <= mmem_q;
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end
      else
      begin
         s1_valid <= issue;
         s2_valid <= s1_valid;
      end
   end

   assign alu_op = s2.alu_op;
   assign byte_op = s2.byte_op;
   assign byte_pos = s2.pos;
   assign byte_len = s2.len;

   // Result register doubles as the last write-back for bypass
   always_ff @(posedge clk_a)
   begin
      result_out.dest_to_m <= s2.dest_to_m;
      result_out.dest_addr <= s2.dest_addr;
      result_out.data <= wb_y;
      if (reset)
         result_out.valid <= 1'b0;
      else
         result_out.valid <= s2_valid;
   end

   assign wb_a_addr = s2.dest_addr;
   assign wb_a_data = wb_y;
   assign wb_a_wren = s2_valid && !s2.dest_to_m;

   // Host M loads share the write port, only legal when idle
   assign host_m = host_load.valid && host_load.to_m;
   assign mmem_waddr = host_m ? host_load.addr[MMEM_AW-1:0] : s2.dest_addr[MMEM_AW-1:0];
   assign mmem_wdata = host_m ? host_load.data : wb_y;
   assign mmem_wren = host_m || (s2_valid && s2.dest_to_m);

   a_queue_no_overflow: assert property (@(posedge clk_a) disable iff (reset)
      uinst_in.valid |-> (q_count < UINST_CREDITS) || issue);

   a_result_credit_bound: assert property (@(posedge clk_a) disable iff (reset)
      rcred <= RESULT_CREDITS);

   a_load_only_idle: assert property (@(posedge clk_a) disable iff (reset)
      host_load.valid |-> !s1_valid && !s2_valid && (q_count == '0));

endmodule

`default_nettype wire

//--- src/amem_datapath_top.sv
// A-memory datapath top: controller, A and M memories,
// ALU and byte unit
`timescale 1ns/1ps
`default_nettype none

module amem_datapath_top (
   input  wire logic                      clk_a,
   input  wire logic                      reset,
   input  wire cadr_uinst_pkg::uinst_in_t uinst_in,
   output logic                           uinst_credit,
   input  wire logic                      result_credit,
   output cadr_uinst_pkg::result_t        result_out,
   input  wire cadr_mem_pkg::mem_load_t   host_load
);
   import cadr_mem_pkg::*;
   import cadr_uinst_pkg::*;

   logic [AMEM_AW-1:0]  amem_raddr;
   logic                amem_rden;
   logic [WORD_W-1:0]   amem_q;
   logic [MMEM_AW-1:0]  mmem_raddr;
   logic                mmem_rden;
   logic [WORD_W-1:0]   mmem_q;
   logic [AMEM_AW-1:0]  wb_a_addr;
   logic [WORD_W-1:0]   wb_a_data;
   logic                wb_a_wren;
   logic [MMEM_AW-1:0]  mmem_waddr;
   logic [WORD_W-1:0]   mmem_wdata;
   logic                mmem_wren;
   alu_op_e             alu_op;
   byte_op_e            byte_op;
   logic [BYTE_FW-1:0]  byte_pos;
   logic [BYTE_FW-1:0]  byte_len;
   logic [WORD_W-1:0]   opnd_a;
   logic [WORD_W-1:0]   opnd_m;
   logic [WORD_W-1:0]   alu_y;
   logic [WORD_W-1:0]   byte_y;

   uinst_ctrl u_ctrl (
      .clk_a         (clk_a),
      .reset         (reset),
      .uinst_in      (uinst_in),
      .uinst_credit  (uinst_credit),
      .result_credit (result_credit),
      .result_out    (result_out),
      .amem_raddr    (amem_raddr),
      .amem_rden     (amem_rden),
      .mmem_raddr    (mmem_raddr),
      .mmem_rden     (mmem_rden),
      .wb_a_addr     (wb_a_addr),
      .wb_a_data     (wb_a_data),
      .wb_a_wren     (wb_a_wren),
      .mmem_waddr    (mmem_waddr),
      .mmem_wdata    (mmem_wdata),
      .mmem_wren     (mmem_wren),
      .host_load     (host_load),
      .amem_q        (amem_q),
      .mmem_q        (mmem_q),
      .alu_op        (alu_op),
      .byte_op       (byte_op),
      .byte_pos      (byte_pos),
      .byte_len      (byte_len),
      .opnd_a        (opnd_a),
      .opnd_m        (opnd_m),
      .alu_y         (alu_y),
      .byte_y        (byte_y)
   );

   // Host A loads go in through port a
   amem_dpram u_amem (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (amem_raddr),
      .data_a    (host_load.data),
      .wren_a    (host_load.valid && !host_load.to_m),
      .rden_a    (amem_rden),
      .q_a       (amem_q),
      .address_b (wb_a_addr),
      .data_b    (wb_a_data),
      .wren_b    (wb_a_wren)
   );

   mmem_regfile u_mmem (
      .clk_a (clk_a),
      .reset (reset),
      .raddr (mmem_raddr),
      .rden  (mmem_rden),
      .rdata (mmem_q),
      .waddr (mmem_waddr),
      .wdata (mmem_wdata),
      .wren  (mmem_wren)
   );

   alu_unit u_alu (
      .op (alu_op),
      .a  (opnd_a),
      .m  (opnd_m),
      .y  (alu_y)
   );

   byte_unit u_byte (
      .op  (byte_op),
      .pos (byte_pos),
      .len (byte_len),
      .a   (opnd_a),
      .m   (opnd_m),
      .y   (byte_y)
   );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_a,
   output logic reset
);

   // 40 ns period
   initial
   begin
      clk_a = 1'b0;
      forever #20 clk_a = ~clk_a;
   end

   // Held over four rising edges, released on a falling edge
   initial
   begin
      reset = 1'b1;
      repeat (4) @(negedge clk_a);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

//--- testbench/tb_checker.sv
// Testbench checker: memory model, reference function,
// result comparison and per-test report lines
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
   input  wire logic                        clk_a,
   input  wire logic                        reset,
   input  wire cadr_uinst_pkg::uinst_in_t   uinst_in,
   input  wire logic                        uinst_credit,
   input  wire logic                        result_credit,
   input  wire cadr_uinst_pkg::result_t     result_out,
   input  wire cadr_mem_pkg::mem_load_t     host_load
);
   import cadr_mem_pkg::*;
   import cadr_uinst_pkg::*;

   logic [WORD_W-1:0] a_model [AMEM_WORDS];
   logic [WORD_W-1:0] m_model [MMEM_WORDS];
   uinst_u            issued [$];
   int n_sent = 0;
   int n_recv = 0;
   int n_ret = 0;
   int n_cred = 0;
   int err_count = 0;
   int mark_recv = 0;
   int mark_err = 0;

   // Expected word from the ALU and rotate-and-mask rules
   function automatic logic [WORD_W-1:0] expect_data(
      input uinst_u             u,
      input logic [WORD_W-1:0]  a,
      input logic [WORD_W-1:0]  m
   );
      logic [WORD_W-1:0] y;
      logic [4:0]        p;
      int                n;
      y = '0;
      p = u.bfld.pos;
      n = int'(u.bfld.len) + 1;
      if (u.alu.kind == KIND_ALU)
      begin
         case (u.alu.alu_op)
            ALU_ADD:    y = a + m;
            ALU_SUB:    y = a - m;
            ALU_AND:    y = a & m;
            ALU_OR:     y = a | m;
            ALU_XOR:    y = a ^ m;
            ALU_PASS_A: y = a;
            ALU_PASS_M: y = m;
            default:    y = '0;
         endcase
      end
      else if (u.bfld.byte_op == BYTE_LDB)
      begin
         for (int i = 0; i < n; i++)
            y[5'(i)] = m[p + 5'(i)];
      end
      else
      begin
         y = a;
         for (int i = 0; i < n; i++)
            y[p + 5'(i)] = m[5'(i)];
      end
      return y;
   endfunction

   task automatic check_result();
      uinst_u            u;
      logic [WORD_W-1:0] exp;
      if (issued.size() == 0)
      begin
         $display("Result arrived with no instruction outstanding at %0t", $time);
         err_count++;
         return;
      end
      u = issued.pop_front();
      exp = expect_data(u, a_model[u.alu.a_addr], m_model[u.alu.m_addr]);
      if (result_out.data !== exp)
      begin
         $display("ERR %0t: result %0d data %h, expected %h",
                  $time, n_recv, result_out.data, exp);
         err_count++;
      end
      if (result_out.dest_to_m !== u.alu.dest_to_m ||
          result_out.dest_addr !== u.alu.dest_addr)
      begin
         $display("ERR %0t: result %0d dest %b/%0d, expected %b/%0d", $time, n_recv,
                  result_out.dest_to_m, result_out.dest_addr,
                  u.alu.dest_to_m, u.alu.dest_addr);
         err_count++;
      end
      if (u.alu.dest_to_m)
         m_model[u.alu.dest_addr[MMEM_AW-1:0]] = exp;
      else
         a_model[u.alu.dest_addr] = exp;
      n_recv++;
   endtask

   always @(posedge clk_a)
   begin
      if (!reset)
      begin
         if (host_load.valid && host_load.to_m)
            m_model[host_load.addr[MMEM_AW-1:0]] = host_load.data;
         else if (host_load.valid)
            a_model[host_load.addr] = host_load.data;
         if (uinst_in.valid)
         begin
            issued.push_back(uinst_in.uinst);
            n_sent++;
         end
         if (uinst_credit)
            n_cred++;
         if (result_credit)
            n_ret++;
         if (result_out.valid)
            check_result();
         if (n_recv - n_ret > RESULT_CREDITS)
         begin
            $display("More than %0d results outstanding at %0t", RESULT_CREDITS, $time);
            err_count++;
         end
      end
   end

   task automatic end_test(input string name);
      if (n_cred != n_sent)
      begin
         $display("Input credit pulses (%0d) do not match instructions sent (%0d)",
                  n_cred, n_sent);
         err_count++;
      end
      $display("test %s: %0d results, %0d errors", name,
               n_recv - mark_recv, err_count - mark_err);
      mark_recv = n_recv;
      mark_err = err_count;
   endtask

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
// Testbench top with the DUT, stimulus, credit handling and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_top;
   import cadr_mem_pkg::*;
   import cadr_uinst_pkg::*;

   localparam int N_LOAD = 96;
   localparam int N_INSTR = 196;
   localparam int LIMIT = 20 * N_INSTR + 4 * N_LOAD + 400;

   logic       clk_a;
   logic       reset;
   uinst_in_t  uinst_in;
   logic       uinst_credit;
   logic       result_credit;
   result_t    result_out;
   mem_load_t  host_load;
   logic       withhold;
   int sent_cnt = 0;
   int back_cnt = 0;
   int recv_cnt = 0;
   int ret_cnt = 0;
   int ret_delay = 0;
   int cycles = 0;
   int mark;
   int total_errs;

   tb_clock_gen u_clk (
      .clk_a (clk_a),
      .reset (reset)
   );

   amem_datapath_top DUT (
      .clk_a         (clk_a),
      .reset         (reset),
      .uinst_in      (uinst_in),
      .uinst_credit  (uinst_credit),
      .result_credit (result_credit),
      .result_out    (result_out),
      .host_load     (host_load)
   );

   tb_checker u_checker (
      .clk_a         (clk_a),
      .reset         (reset),
      .uinst_in      (uinst_in),
      .uinst_credit  (uinst_credit),
      .result_credit (result_credit),
      .result_out    (result_out),
      .host_load     (host_load)
   );

   function automatic uinst_u make_alu(input alu_op_e op, input logic dm,
      input logic [9:0] dest, input logic [9:0] a, input logic [4:0] m);
      uinst_u u;
      u = '0;
      u.alu.kind = KIND_ALU;
      u.alu.dest_to_m = dm;
      u.alu.dest_addr = dest;
      u.alu.a_addr = a;
      u.alu.m_addr = m;
      u.alu.alu_op = op;
      return u;
   endfunction

   function automatic uinst_u make_byte(input byte_op_e op, input logic dm,
      input logic [9:0] dest, input logic [9:0] a, input logic [4:0] m,
      input logic [4:0] pos, input logic [4:0] len);
      uinst_u u;
      u = '0;
      u.bfld.kind = KIND_BYTE;
      u.bfld.dest_to_m = dm;
      u.bfld.dest_addr = dest;
      u.bfld.a_addr = a;
      u.bfld.m_addr = m;
      u.bfld.byte_op = op;
      u.bfld.pos = pos;
      u.bfld.len = len;
      return u;
   endfunction

   // Destination inside the loaded region of the chosen memory
   function automatic logic [9:0] rand_dest(input logic dm);
      return dm ? 10'($urandom_range(0, 31)) : 10'($urandom_range(0, 63));
   endfunction

   task automatic send_uinst(input uinst_u u);
      while (sent_cnt - back_cnt >= UINST_CREDITS)
         @(negedge clk_a);
      uinst_in.valid = 1'b1;
      uinst_in.uinst = u;
      sent_cnt++;
      @(negedge clk_a);
      uinst_in.valid = 1'b0;
   endtask

   task automatic load_word(input logic to_m, input logic [9:0] addr,
      input logic [31:0] data);
      host_load.valid = 1'b1;
      host_load.to_m = to_m;
      host_load.addr = addr;
      host_load.data = data;
      @(negedge clk_a);
      host_load.valid = 1'b0;
   endtask

   task automatic drain();
      while (recv_cnt != sent_cnt)
         @(negedge clk_a);
      repeat (6) @(negedge clk_a);
   endtask

   always @(posedge clk_a)
   begin
      if (!reset && uinst_credit)
         back_cnt++;
      if (!reset && result_out.valid)
         recv_cnt++;
   end

   // Consumer returns one credit per result after a random delay
   always @(negedge clk_a)
   begin
      result_credit = 1'b0;
      if (!reset && !withhold && recv_cnt > ret_cnt)
      begin
         if (ret_delay == 0)
         begin
            result_credit = 1'b1;
            ret_cnt++;
            ret_delay = int'($urandom_range(0, 3));
         end
         else
            ret_delay--;
      end
   end

   always @(posedge clk_a)
   begin
      cycles++;
      if (cycles > LIMIT)
      begin
         $display("Timeout: run did not finish within %0d cycles", LIMIT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   initial
   begin
      uinst_in = '0;
      result_credit = 1'b0;
      host_load = '0;
      withhold = 1'b0;
      void'($urandom(32'h89ac_8d9d));
      @(negedge clk_a);
      while (reset)
         @(negedge clk_a);

      for (int i = 0; i < 64; i++)
         load_word(1'b0, 10'(i), $urandom);
      for (int i = 0; i < 32; i++)
         load_word(1'b1, 10'(i), $urandom);
      repeat (4) @(negedge clk_a);
      for (int i = 0; i < 64; i++)
         send_uinst(make_alu(ALU_PASS_A, 1'b0, 10'(i), 10'(i), 5'd0));
      for (int i = 0; i < 32; i++)
         send_uinst(make_alu(ALU_PASS_M, 1'b1, 10'(i), 10'd0, 5'(i)));
      drain();
      u_checker.end_test("host load and read");

      for (int i = 0; i < 40; i++)
      begin
         logic dm;
         dm = 1'($urandom_range(0, 1));
         send_uinst(make_alu(alu_op_e'(3'(i)), dm, rand_dest(dm),
                    10'($urandom_range(0, 63)), 5'($urandom_range(0, 31))));
      end
      drain();
      u_checker.end_test("alu operations");

      for (int i = 0; i < 36; i++)
      begin
         logic       dm;
         logic [4:0] pos;
         logic [4:0] len;
         dm = 1'($urandom_range(0, 1));
         pos = (i % 5 == 0) ? 5'd0 : 5'($urandom_range(0, 31));
         len = (i % 3 == 0) ? 5'd31 : 5'($urandom_range(0, 31));
         send_uinst(make_byte(byte_op_e'(1'(i)), dm, rand_dest(dm),
                    10'($urandom_range(0, 63)), 5'($urandom_range(0, 31)), pos, len));
      end
      drain();
      u_checker.end_test("load and deposit byte");

      // Destination alternates between A10 and M7 and each reads both
      for (int i = 0; i < 16; i++)
      begin
         if (i % 3 == 2)
            send_uinst(make_byte(BYTE_DPB, 1'(i), 10'(i % 2 ? 7 : 10), 10'd10, 5'd7,
                       5'($urandom_range(0, 31)), 5'($urandom_range(0, 31))));
         else
            send_uinst(make_alu(i % 3 ? ALU_XOR : ALU_ADD, 1'(i),
                       10'(i % 2 ? 7 : 10), 10'd10, 5'd7));
      end
      drain();
      u_checker.end_test("dependent chain");

      while (ret_cnt != recv_cnt)
         @(negedge clk_a);
      withhold = 1'b1;
      mark = recv_cnt;
      fork
         begin
            for (int i = 0; i < 8; i++)
               send_uinst(make_alu(ALU_ADD, 1'b0, 10'(20 + i), 10'(19 + i), 5'(i)));
         end
         begin
            repeat (40) @(negedge clk_a);
            if (recv_cnt - mark != RESULT_CREDITS)
            begin
               $display("With credits withheld %0d results arrived instead of %0d",
                        recv_cnt - mark, RESULT_CREDITS);
               u_checker.err_count++;
            end
            if (sent_cnt - back_cnt != UINST_CREDITS)
            begin
               $display("Input credits kept returning while results were stalled");
               u_checker.err_count++;
            end
            withhold = 1'b0;
         end
      join
      drain();
      u_checker.end_test("credit back-pressure");

      total_errs = u_checker.err_count;
      $display("sent %0d, results %0d, errors %0d", sent_cnt, recv_cnt, total_errs);
      if (total_errs == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
src/cadr_mem_pkg.sv
src/cadr_uinst_pkg.sv
src/amem_dpram.sv
src/mmem_regfile.sv
src/alu_unit.sv
src/byte_unit.sv
src/uinst_ctrl.sv
src/amem_datapath_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tb_top
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(wildcard src/*.sv testbench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
